//--- logic/fft_num_pkg.sv
// fixed-point number formats for the 8-point FFT datapath
// per-stage sample types and the Q6 twiddle table
package fft_num_pkg;

  // input samples are signed Q5.8
  localparam int int_width  = 5;
  localparam int frac_width = 8;
  localparam int in_width   = int_width + frac_width;

  // each butterfly stage adds one bit of headroom
  typedef logic signed [in_width-1:0] in_t;
  typedef logic signed [in_width:0]   s1_t;
  typedef logic signed [in_width+1:0] s2_t;
  typedef logic signed [in_width+2:0] s3_t;

  localparam int tw_width = 8;
  localparam int tw_shift = 6;

  // W8^k for k = 0..3, scaled by 2^tw_shift
  localparam logic signed [tw_width-1:0] tw_re_table [4] = '{
    8'sd64, 8'sd45, 8'sd0, -8'sd45
  };
  localparam logic signed [tw_width-1:0] tw_im_table [4] = '{
    8'sd0, -8'sd45, -8'sd64, -8'sd45
  };

endpackage

//--- logic/fft_seq_pkg.sv
// frame sequencing definitions for the 8-point FFT
// frame length, sequencer states and sample counter
package fft_seq_pkg;

  localparam int frame_len  = 8;
  localparam int frame_bits = $clog2(frame_len);

  // frame sequencer states
  typedef enum logic [1:0] {
    seq_idle,
    seq_load,
    seq_compute,
    seq_unload
  } seq_state_t;

  // counts samples within one frame
  typedef logic [frame_bits-1:0] frame_cnt_t;

endpackage

//--- logic/sdf_stage.sv
`timescale 1ns/1ps

// radix-2 DIF single-path delay-feedback butterfly stage
// difference path is rotated by a W8 twiddle, output one bit wider
module sdf_stage #(
  parameter int  delay_depth  = 4,
  parameter type in_sample_t  = fft_num_pkg::in_t,
  parameter type out_sample_t = fft_num_pkg::s1_t
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  in_sample_t  in_re,
  input  in_sample_t  in_im,
  output logic        out_valid,
  output out_sample_t out_re,
  output out_sample_t out_im
);

  localparam int cnt_w     = (delay_depth > 1) ? $clog2(delay_depth) : 1;
  localparam int tw_bits   = $clog2(fft_seq_pkg::frame_len / 2);
  localparam int tw_stride = fft_seq_pkg::frame_len / 2 / delay_depth;
  localparam int prod_w    = $bits(out_sample_t) + fft_num_pkg::tw_width + 1;

  typedef enum logic [1:0] {
    st_idle,
    st_fill,
    st_bfly,
    st_flush
  } stage_state_t;

  stage_state_t     state, state_nxt;
  logic [cnt_w-1:0] cnt, cnt_nxt;
  logic             pend, pend_nxt;
  logic             last;
  logic             fill_go, bfly_go, flush_go, step;
  logic             out_valid_nxt;

  // delay line, index 0 is the newest entry
  out_sample_t line_re [delay_depth];
  out_sample_t line_im [delay_depth];
  out_sample_t push_re, push_im;

  out_sample_t x_re, x_im;
  out_sample_t sum_re, sum_im, dif_re, dif_im;
  out_sample_t rot_re, rot_im;

  logic [tw_bits-1:0]                      tw_idx;
  logic signed [fft_num_pkg::tw_width-1:0] tw_re, tw_im;
  logic signed [prod_w-1:0]                prod_re, prod_im;

  assign last = (cnt == cnt_w'(delay_depth - 1));

  // butterfly between the oldest stored sample and the new one
  assign x_re   = out_sample_t'(in_re);
  assign x_im   = out_sample_t'(in_im);
  assign sum_re = line_re[delay_depth-1] + x_re;
  assign sum_im = line_im[delay_depth-1] + x_im;
  assign dif_re = line_re[delay_depth-1] - x_re;
  assign dif_im = line_im[delay_depth-1] - x_im;

  // twiddle for difference k is W8^(k * stride)
  assign tw_idx = tw_bits'(cnt * tw_stride);
  assign tw_re  = fft_num_pkg::tw_re_table[tw_idx];
  assign tw_im  = fft_num_pkg::tw_im_table[tw_idx];

  assign prod_re = line_re[delay_depth-1] * tw_re - line_im[delay_depth-1] * tw_im;
  assign prod_im = line_re[delay_depth-1] * tw_im + line_im[delay_depth-1] * tw_re;
  // floor shift back to sample scale, then wrap to output width
  assign rot_re  = out_sample_t'(prod_re >>> fft_num_pkg::tw_shift);
  assign rot_im  = out_sample_t'(prod_im >>> fft_num_pkg::tw_shift);

  // fill also drains differences left by the previous block
  assign fill_go  = (state == st_idle || state == st_fill) && in_valid;
  assign bfly_go  = (state == st_bfly) && in_valid;
  assign flush_go = (state == st_flush) || (state == st_fill && pend && !in_valid);
  assign step     = fill_go || bfly_go || flush_go;

  always_comb begin
    state_nxt     = state;
    cnt_nxt       = cnt;
    pend_nxt      = pend;
    push_re       = x_re;
    push_im       = x_im;
    out_valid_nxt = bfly_go || flush_go || (fill_go && pend);
    if (bfly_go) begin
      push_re = dif_re;
      push_im = dif_im;
    end else if (flush_go) begin
      push_re = '0;
      push_im = '0;
    end
    if (step) begin
      cnt_nxt = last ? '0 : cnt + 1'b1;
      if (fill_go) begin
        state_nxt = last ? st_bfly : st_fill;
        pend_nxt  = last ? 1'b0 : pend;
      end else if (bfly_go) begin
        // differences now wait in the line for the next half
        state_nxt = last ? st_fill : st_bfly;
        pend_nxt  = last;
      end else begin
        state_nxt = last ? st_idle : st_flush;
        pend_nxt  = !last;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      cnt       <= '0;
      pend      <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      state     <= state_nxt;
      cnt       <= cnt_nxt;
      pend      <= pend_nxt;
      out_valid <= out_valid_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      line_re[0] <= push_re;
      line_im[0] <= push_im;
      for (int i = 1; i < delay_depth; i++) begin
        line_re[i] <= line_re[i-1];
        line_im[i] <= line_im[i-1];
      end
    end
    out_re <= bfly_go ? sum_re : rot_re;
    out_im <= bfly_go ? sum_im : rot_im;
  end

endmodule

//--- logic/fft_frame_seq.sv
`timescale 1ns/1ps

// frame sequencer, accepts one frame and feeds stage 1
// collects bit-reversed stage 3 results and plays them out in natural order
module fft_frame_seq (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid_in,
  input  fft_num_pkg::in_t data_in_re,
  input  fft_num_pkg::in_t data_in_im,
  output logic             ready,
  output logic             fe_valid,
  output fft_num_pkg::in_t fe_re,
  output fft_num_pkg::in_t fe_im,
  input  logic             be_valid,
  input  fft_num_pkg::s3_t be_re,
  input  fft_num_pkg::s3_t be_im,
  output logic             valid_out,
  output fft_num_pkg::s3_t data_out_re,
  output fft_num_pkg::s3_t data_out_im
);

  fft_seq_pkg::seq_state_t state;
  fft_seq_pkg::frame_cnt_t cnt;
  fft_seq_pkg::frame_cnt_t wr_slot, rd_slot;

  logic take, take_q;
  logic cnt_last;
  logic res_wr, out_load;

  fft_num_pkg::in_t in_re_q, in_im_q;

  // result buffer in natural bin order
  fft_num_pkg::s3_t res_re [fft_seq_pkg::frame_len];
  fft_num_pkg::s3_t res_im [fft_seq_pkg::frame_len];

  assign ready    = (state == fft_seq_pkg::seq_idle);
  // source holds valid_in for the whole frame once it starts
  assign take     = (ready && valid_in) || (state == fft_seq_pkg::seq_load);
  assign cnt_last = (cnt == fft_seq_pkg::frame_cnt_t'(fft_seq_pkg::frame_len - 1));

  // n-th result belongs to bin bitrev(n)
  assign wr_slot  = {<<{cnt}};
  assign res_wr   = (state == fft_seq_pkg::seq_compute) && be_valid;
  // bin 0 goes out together with the last write
  assign out_load = (res_wr && cnt_last) ||
                    (state == fft_seq_pkg::seq_unload && cnt != '0);
  assign rd_slot  = (state == fft_seq_pkg::seq_unload) ? cnt : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= fft_seq_pkg::seq_idle;
      cnt       <= '0;
      take_q    <= 1'b0;
      fe_valid  <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      take_q    <= take;
      fe_valid  <= take_q;
      valid_out <= out_load;
      case (state)
        fft_seq_pkg::seq_idle: begin
          if (valid_in) begin
            state <= fft_seq_pkg::seq_load;
            cnt   <= fft_seq_pkg::frame_cnt_t'(1);
          end
        end
        fft_seq_pkg::seq_load: begin
          // wraps to zero for the compute phase
          cnt <= cnt + 1'b1;
          if (cnt_last) state <= fft_seq_pkg::seq_compute;
        end
        fft_seq_pkg::seq_compute: begin
          if (be_valid) begin
            cnt <= cnt + 1'b1;
            if (cnt_last) begin
              state <= fft_seq_pkg::seq_unload;
              cnt   <= fft_seq_pkg::frame_cnt_t'(1);
            end
          end
        end
        default: begin
          // one idle cycle after bin 7 before ready returns
          if (cnt == '0) state <= fft_seq_pkg::seq_idle;
          else cnt <= cnt + 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    in_re_q <= data_in_re;
    in_im_q <= data_in_im;
    fe_re   <= in_re_q;
    fe_im   <= in_im_q;
    if (res_wr) begin
      res_re[wr_slot] <= be_re;
      res_im[wr_slot] <= be_im;
    end
    if (out_load) begin
      data_out_re <= res_re[rd_slot];
      data_out_im <= res_im[rd_slot];
    end
  end

endmodule

//--- logic/fft8_top.sv
`timescale 1ns/1ps

// streaming 8-point radix-2 DIF FFT
// frame sequencer driving three delay-feedback stages of depth 4, 2 and 1
module fft8_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid_in,
  input  fft_num_pkg::in_t data_in_re,
  input  fft_num_pkg::in_t data_in_im,
  output logic             ready,
  output logic             valid_out,
  output fft_num_pkg::s3_t data_out_re,
  output fft_num_pkg::s3_t data_out_im
);

  // sequencer to stage 1
  logic             fe_valid;
  fft_num_pkg::in_t fe_re, fe_im;

  // between stages
  logic             s1_valid, s2_valid;
  fft_num_pkg::s1_t s1_re, s1_im;
  fft_num_pkg::s2_t s2_re, s2_im;

  // stage 3 back to the sequencer, bit-reversed order
  logic             be_valid;
  fft_num_pkg::s3_t be_re, be_im;

  fft_frame_seq seq_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_in    (valid_in),
    .data_in_re  (data_in_re),
    .data_in_im  (data_in_im),
    .ready       (ready),
    .fe_valid    (fe_valid),
    .fe_re       (fe_re),
    .fe_im       (fe_im),
    .be_valid    (be_valid),
    .be_re       (be_re),
    .be_im       (be_im),
    .valid_out   (valid_out),
    .data_out_re (data_out_re),
    .data_out_im (data_out_im)
  );

  sdf_stage #(
    .delay_depth  (4),
    .in_sample_t  (fft_num_pkg::in_t),
    .out_sample_t (fft_num_pkg::s1_t)
  ) stage1_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (fe_valid),
    .in_re     (fe_re),
    .in_im     (fe_im),
    .out_valid (s1_valid),
    .out_re    (s1_re),
    .out_im    (s1_im)
  );

  sdf_stage #(
    .delay_depth  (2),
    .in_sample_t  (fft_num_pkg::s1_t),
    .out_sample_t (fft_num_pkg::s2_t)
  ) stage2_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (s1_valid),
    .in_re     (s1_re),
    .in_im     (s1_im),
    .out_valid (s2_valid),
    .out_re    (s2_re),
    .out_im    (s2_im)
  );

  sdf_stage #(
    .delay_depth  (1),
    .in_sample_t  (fft_num_pkg::s2_t),
    .out_sample_t (fft_num_pkg::s3_t)
  ) stage3_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (s2_valid),
    .in_re     (s2_re),
    .in_im     (s2_im),
    .out_valid (be_valid),
    .out_re    (be_re),
    .out_im    (be_im)
  );

endmodule

//--- tb/fft8_ref.svh
// bit-exact reference model of the fixed-point 8-point DIF FFT
// Q6 twiddles with floor shift, each stage wrapped to its own width
`ifndef FFT8_REF_SVH
`define FFT8_REF_SVH

// W8^k for k = 0..3 in Q6
localparam int ref_tw_re [4] = '{64, 45, 0, -45};
localparam int ref_tw_im [4] = '{0, -45, -64, -45};

// two's complement wrap of v into w bits
function automatic int wrap_to(input int v, input int w);
  int m;
  m = v & ((1 << w) - 1);
  if (m >= (1 << (w - 1))) m = m - (1 << w);
  return m;
endfunction

// one radix-2 DIF pass with butterfly span d and output width w
task automatic ref_stage(input int d, input int w, input int xr[8], input int xi[8],
                         output int yr[8], output int yi[8]);
  int dr;
  int di;
  int t;
  for (int b = 0; b < 8; b += 2 * d) begin
    for (int k = 0; k < d; k++) begin
      yr[b+k] = wrap_to(xr[b+k] + xr[b+k+d], w);
      yi[b+k] = wrap_to(xi[b+k] + xi[b+k+d], w);
      dr = wrap_to(xr[b+k] - xr[b+k+d], w);
      di = wrap_to(xi[b+k] - xi[b+k+d], w);
      t = k * (4 / d);
      yr[b+d+k] = wrap_to((dr * ref_tw_re[t] - di * ref_tw_im[t]) >>> 6, w);
      yi[b+d+k] = wrap_to((dr * ref_tw_im[t] + di * ref_tw_re[t]) >>> 6, w);
    end
  end
endtask

// full transform, results in natural bin order
task automatic ref_fft8(input int xr[8], input int xi[8], output int yr[8], output int yi[8]);
  int ar[8], ai[8];
  int br[8], bi[8];
  int cr[8], ci[8];
  ref_stage(4, 14, xr, xi, ar, ai);
  ref_stage(2, 15, ar, ai, br, bi);
  ref_stage(1, 16, br, bi, cr, ci);
  // stage 3 leaves the bins bit-reversed
  for (int n = 0; n < 8; n++) begin
    yr[{n[0], n[1], n[2]}] = cr[n];
    yi[{n[0], n[1], n[2]}] = ci[n];
  end
endtask

`endif

//--- tb/fft8_tb.sv
`timescale 1ns/1ps

// testbench for the 8-point FFT
// runs a table of frames, checks bins, flags and handshake timing
module fft8_tb;

  localparam int clk_period  = 100;
  localparam int drive_delay = 5;
  localparam int n_rows      = 7;
  localparam int n_pts       = fft_seq_pkg::frame_len;
  localparam int out_wait    = 40;
  localparam int wd_cycles   = n_rows * 60 + 50;
  localparam int exp_direct  = 0;
  localparam int exp_model   = 1;

  logic             clk;
  logic             rst_n;
  logic             valid_in;
  fft_num_pkg::in_t data_in_re;
  fft_num_pkg::in_t data_in_im;
  logic             ready;
  logic             valid_out;
  fft_num_pkg::s3_t data_out_re;
  fft_num_pkg::s3_t data_out_im;

  // stimulus table, one frame per row
  string row_name [n_rows];
  int    row_mode [n_rows];
  bit    row_pulse [n_rows];
  bit    row_reset [n_rows];
  int    row_in_re [n_rows][n_pts];
  int    row_in_im [n_rows][n_pts];
  int    row_exp_re [n_rows][n_pts];
  int    row_exp_im [n_rows][n_pts];

  int exp_re [n_pts];
  int exp_im [n_pts];
  int seed;
  int err_cnt;
  int pass_cnt;
  int fail_cnt;

  `include "fft8_ref.svh"

  fft8_top fft8_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_in    (valid_in),
    .data_in_re  (data_in_re),
    .data_in_im  (data_in_im),
    .ready       (ready),
    .valid_out   (valid_out),
    .data_out_re (data_out_re),
    .data_out_im (data_out_im)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog: simulation timed out after %0d cycles", wd_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // outputs are stable and inputs change a few ns after the edge
  task automatic tick();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic check_bin(input int k, input fft_num_pkg::s3_t got_re,
                           input fft_num_pkg::s3_t got_im, input fft_num_pkg::s3_t want_re,
                           input fft_num_pkg::s3_t want_im);
    if (got_re !== want_re || got_im !== want_im) begin
      $display("[FAIL] t=%0t bin %0d got (%0d, %0d) expected (%0d, %0d)",
               $time, k, got_re, got_im, want_re, want_im);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic want);
    if (got !== want) begin
      $display("[FAIL] t=%0t %s is %b, expected %b", $time, what, got, want);
      err_cnt++;
    end
  endtask

  task automatic hold_reset(input int cycles);
    rst_n    = 1'b0;
    valid_in = 1'b0;
    repeat (cycles) tick();
    rst_n = 1'b1;
  endtask

  task automatic fill_table();
    for (int r = 0; r < n_rows; r++) begin
      row_mode[r]  = exp_model;
      row_pulse[r] = 1'b0;
      row_reset[r] = 1'b0;
      for (int i = 0; i < n_pts; i++) begin
        row_in_re[r][i]  = $random(seed) % 1025;
        row_in_im[r][i]  = $random(seed) % 1025;
        row_exp_re[r][i] = 0;
        row_exp_im[r][i] = 0;
      end
    end
    // impulse at x0 spreads evenly over all bins
    row_name[0] = "impulse";
    row_mode[0] = exp_direct;
    for (int i = 0; i < n_pts; i++) begin
      row_in_re[0][i]  = (i == 0) ? 200 : 0;
      row_in_im[0][i]  = (i == 0) ? -77 : 0;
      row_exp_re[0][i] = 200;
      row_exp_im[0][i] = -77;
      row_in_re[1][i]  = 300;
      row_in_im[1][i]  = -125;
    end
    row_name[1]      = "dc";
    row_mode[1]      = exp_direct;
    row_exp_re[1][0] = 2400;
    row_exp_im[1][0] = -1000;
    row_name[2]  = "random_a";
    row_name[3]  = "random_b";
    // a stray frame would corrupt the plain frame right after it
    row_name[4]  = "busy_pulse";
    row_pulse[4] = 1'b1;
    row_name[5]  = "random_c";
    row_name[6]  = "reset_mid_frame";
    row_reset[6] = 1'b1;
  endtask

  task automatic build_expected(input int r);
    int xr [n_pts];
    int xi [n_pts];
    for (int i = 0; i < n_pts; i++) begin
      xr[i] = row_in_re[r][i];
      xi[i] = row_in_im[r][i];
    end
    if (row_mode[r] == exp_model) begin
      ref_fft8(xr, xi, exp_re, exp_im);
    end else begin
      for (int i = 0; i < n_pts; i++) begin
        exp_re[i] = row_exp_re[r][i];
        exp_im[i] = row_exp_im[r][i];
      end
    end
  endtask

  task automatic send_samples(input int r, input int count);
    int waited;
    waited = 0;
    while (!ready && waited < out_wait) begin
      tick();
      waited++;
    end
    if (!ready) begin
      $display("frame %s: ready never went high", row_name[r]);
      err_cnt++;
    end
    for (int i = 0; i < count; i++) begin
      valid_in   = 1'b1;
      data_in_re = fft_num_pkg::in_t'(row_in_re[r][i]);
      data_in_im = fft_num_pkg::in_t'(row_in_im[r][i]);
      tick();
      check_flag("ready during load", ready, 1'b0);
    end
    valid_in = 1'b0;
  endtask

  task automatic await_and_collect(input int r);
    int waited;
    waited = 0;
    while (!valid_out && waited < out_wait) begin
      // stray request while busy must not start a frame
      valid_in = row_pulse[r] && waited == 6;
      check_flag("ready while busy", ready, 1'b0);
      tick();
      waited++;
    end
    valid_in = 1'b0;
    if (!valid_out) begin
      $display("frame %s: no output within %0d cycles", row_name[r], out_wait);
      err_cnt++;
    end else begin
      for (int k = 0; k < n_pts; k++) begin
        check_flag("valid_out during playout", valid_out, 1'b1);
        check_flag("ready during playout", ready, 1'b0);
        check_bin(k, data_out_re, data_out_im, fft_num_pkg::s3_t'(exp_re[k]),
                  fft_num_pkg::s3_t'(exp_im[k]));
        tick();
      end
      check_flag("valid_out after bin 7", valid_out, 1'b0);
      check_flag("ready after playout", ready, 1'b1);
    end
  endtask

  task automatic report_test(input string name);
    if (err_cnt == 0) begin
      pass_cnt++;
      $display("test %-16s ok", name);
    end else begin
      fail_cnt++;
      $display("test %-16s failed with %0d errors", name, err_cnt);
    end
  endtask

  initial begin
    seed       = 32'ha42c03b1;
    rst_n      = 1'b0;
    valid_in   = 1'b0;
    data_in_re = '0;
    data_in_im = '0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    err_cnt    = 0;
    fill_table();
    hold_reset(8);
    check_flag("ready after reset", ready, 1'b1);
    check_flag("valid_out after reset", valid_out, 1'b0);
    report_test("power_on_reset");
    for (int r = 0; r < n_rows; r++) begin
      err_cnt = 0;
      if (row_reset[r]) begin
        send_samples(r, 3);
        hold_reset(2);
        check_flag("ready after reset", ready, 1'b1);
        check_flag("valid_out after reset", valid_out, 1'b0);
      end
      build_expected(r);
      send_samples(r, n_pts);
      await_and_collect(r);
      report_test(row_name[r]);
    end
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+tb
logic/fft_num_pkg.sv
logic/fft_seq_pkg.sv
logic/sdf_stage.sv
logic/fft_frame_seq.sv
logic/fft8_top.sv
tb/fft8_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module fft8_tb -o fft8_sim
output="$(./obj_dir/fft8_sim)"
echo "$output"

if echo "$output" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
exit 1
